/* all.f */
+incdir+design
design/id_isa_pkg.sv
design/id_ctrl_pkg.sv
design/id_decoder.sv
design/id_operand_mux.sv
design/id_controller.sv
design/id_stage.sv
verif/id_stage_checker.sv
verif/id_stage_tb.sv

/* design/id_controller.sv */
// Decode stage controller
// ID FSM, stalls, instruction done and ready, PC set and request gating

`timescale 1ns/1ns

module id_controller (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic instr_valid_i,
  input  logic illegal_insn_i,
  input  logic lsu_req_dec_i,
  input  logic branch_dec_i,
  input  logic jump_dec_i,
  input  logic rf_we_dec_i,

  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,

  output logic instr_first_cycle_o,
  output logic lsu_req_o,
  output logic rf_we_o,
  output logic pc_set_o,
  output logic instr_done_o,
  output logic id_in_ready_o
);

  import id_ctrl_pkg::*;

  id_fsm_e id_fsm_q, id_fsm_d;
  logic    instr_exec;
  logic    instr_first_cycle;
  logic    multicycle_done;
  logic    branch_set_q, branch_set_d;
  logic    set_done_q, set_done_d;
  logic    jump_set_raw;
  logic    stall_mem, stall_branch, stall_jump;
  logic    instr_done;

  // Legal valid instructions execute; illegal ones just retire
  assign instr_exec        = instr_valid_i & ~illegal_insn_i;
  assign instr_first_cycle = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Memory ops wait for the response, branch/jump second cycle ends at once
  assign multicycle_done = lsu_req_dec_i ? lsu_resp_valid_i : 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // ID FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    id_fsm_d     = id_fsm_q;
    branch_set_d = 1'b0;
    jump_set_raw = 1'b0;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;

    if (instr_exec) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_req_dec_i) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (branch_dec_i) begin
            // Only taken branches need the target cycle
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (jump_dec_i) begin
            id_fsm_d     = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = branch_dec_i;
            stall_jump   = jump_dec_i;
          end
        end
        default: id_fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (instr_exec) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Branch and jump set
  ////////////////////////////////////////////////////////////////////////////

  // Taken branch decision flopped, target goes out next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
    end
  end

  // Remember a set already sent for this instruction, cleared by done
  assign set_done_d = (branch_set_q | jump_set_raw | set_done_q) & ~instr_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_done_q <= 1'b0;
    end else begin
      set_done_q <= set_done_d;
    end
  end

  assign pc_set_o = (branch_set_q | jump_set_raw) & ~set_done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Stalls, done and gating
  ////////////////////////////////////////////////////////////////////////////

  // Memory op always stalls its first cycle, then until the response
  assign stall_mem  = instr_exec & lsu_req_dec_i & (~lsu_resp_valid_i | instr_first_cycle);
  assign instr_done = instr_valid_i & ~(stall_mem | stall_branch | stall_jump);

  assign lsu_req_o = lsu_req_dec_i & instr_first_cycle & ~illegal_insn_i;
  assign rf_we_o   = rf_we_dec_i & instr_done & ~illegal_insn_i;

  assign instr_first_cycle_o = instr_first_cycle;
  assign instr_done_o        = instr_done;
  assign id_in_ready_o       = instr_done | ~instr_valid_i;

endmodule

/* design/id_ctrl_pkg.sv */
// Control types of the decode stage
// Operand and immediate selects, plus the ID FSM state

package id_ctrl_pkg;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate used as operand B
  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  // ID FSM, second state covers memory waits and branch/jump second cycle
  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

endpackage

/* design/id_decoder.sv */
// RV32I instruction decoder
// Turns the fetched word into control, register addresses and immediates

`timescale 1ns/1ns
`include "id_defs.svh"

module id_decoder (
  input  logic                    instr_valid_i,
  input  logic [`ID_INSTR_W-1:0]  instr_rdata_i,
  input  logic                    instr_first_cycle_i,

  // To controller
  output logic                    illegal_insn_o,
  output logic                    lsu_req_dec_o,
  output logic                    branch_dec_o,
  output logic                    jump_dec_o,
  output logic                    rf_we_dec_o,

  // LSU attributes
  output logic                    lsu_we_o,
  output logic [1:0]              lsu_type_o,
  output logic                    lsu_sign_ext_o,

  // Register file
  output logic                    rf_ren_a_dec_o,
  output logic                    rf_ren_b_dec_o,
  output logic [`ID_REG_AW-1:0]   rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]   rf_raddr_b_o,
  output logic [`ID_REG_AW-1:0]   rf_waddr_o,

  // ALU control and operand selects
  output id_isa_pkg::alu_op_e     alu_operator_o,
  output id_ctrl_pkg::op_a_sel_e  op_a_sel_o,
  output id_ctrl_pkg::op_b_sel_e  op_b_sel_o,
  output id_ctrl_pkg::imm_b_sel_e imm_b_sel_o,

  // Sign extended immediates
  output logic [`ID_XLEN-1:0]     imm_i_o,
  output logic [`ID_XLEN-1:0]     imm_s_o,
  output logic [`ID_XLEN-1:0]     imm_b_o,
  output logic [`ID_XLEN-1:0]     imm_u_o,
  output logic [`ID_XLEN-1:0]     imm_j_o
);

  import id_isa_pkg::*;
  import id_ctrl_pkg::*;

  instr_u instr;
  logic   illegal_insn;
  logic   rf_ren_a;
  logic   rf_ren_b;

  assign instr = instr_rdata_i;

  // Register addresses sit at fixed positions in every format
  assign rf_raddr_a_o = instr.r.rs1;
  assign rf_raddr_b_o = instr.r.rs2;
  assign rf_waddr_o   = instr.r.rd;

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i_o = {{(`ID_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
  assign imm_s_o = {{(`ID_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b_o = {{(`ID_XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                    instr.b.imm4_1, 1'b0};
  assign imm_u_o = {instr.u.imm, 12'b0};
  assign imm_j_o = {{(`ID_XLEN-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                    instr.j.imm10_1, 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Opcode and function decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    illegal_insn   = 1'b0;
    lsu_req_dec_o  = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_type_o     = 2'b00;
    lsu_sign_ext_o = 1'b0;
    branch_dec_o   = 1'b0;
    jump_dec_o     = 1'b0;
    rf_we_dec_o    = 1'b0;
    rf_ren_a       = 1'b0;
    rf_ren_b       = 1'b0;
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_B_I;

    unique case (instr.r.opcode)
      OPCODE_OP: begin
        rf_ren_a    = 1'b1;
        rf_ren_b    = 1'b1;
        rf_we_dec_o = 1'b1;
        op_b_sel_o  = OP_B_REG_B;
        unique case ({instr.r.funct7, instr.r.funct3})
          {FUNCT7_BASE, 3'b000}: alu_operator_o = ALU_ADD;
          {FUNCT7_ALT,  3'b000}: alu_operator_o = ALU_SUB;
          {FUNCT7_BASE, 3'b001}: alu_operator_o = ALU_SLL;
          {FUNCT7_BASE, 3'b010}: alu_operator_o = ALU_SLT;
          {FUNCT7_BASE, 3'b011}: alu_operator_o = ALU_SLTU;
          {FUNCT7_BASE, 3'b100}: alu_operator_o = ALU_XOR;
          {FUNCT7_BASE, 3'b101}: alu_operator_o = ALU_SRL;
          {FUNCT7_ALT,  3'b101}: alu_operator_o = ALU_SRA;
          {FUNCT7_BASE, 3'b110}: alu_operator_o = ALU_OR;
          {FUNCT7_BASE, 3'b111}: alu_operator_o = ALU_AND;
          default:               illegal_insn   = 1'b1;
        endcase
      end

      OPCODE_OP_IMM: begin
        rf_ren_a    = 1'b1;
        rf_we_dec_o = 1'b1;
        unique case (instr.i.funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          // Shifts keep funct7 in the upper immediate bits
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_insn   = (instr.r.funct7 != FUNCT7_BASE);
          end
          default: begin
            alu_operator_o = (instr.r.funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
            illegal_insn   = (instr.r.funct7 != FUNCT7_BASE) &&
                             (instr.r.funct7 != FUNCT7_ALT);
          end
        endcase
      end

      OPCODE_LUI: begin
        rf_we_dec_o = 1'b1;
        op_a_sel_o  = OP_A_ZERO;
        imm_b_sel_o = IMM_B_U;
      end

      OPCODE_AUIPC: begin
        rf_we_dec_o = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
      end

      // Target first, link address PC + 4 in the second cycle
      OPCODE_JAL: begin
        jump_dec_o  = 1'b1;
        rf_we_dec_o = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = instr_first_cycle_i ? IMM_B_J : IMM_B_INCR_PC;
      end

      OPCODE_JALR: begin
        jump_dec_o   = 1'b1;
        rf_we_dec_o  = 1'b1;
        rf_ren_a     = 1'b1;
        illegal_insn = (instr.i.funct3 != 3'b000);
        if (!instr_first_cycle_i) begin
          op_a_sel_o  = OP_A_CURRPC;
          imm_b_sel_o = IMM_B_INCR_PC;
        end
      end

      // Compare registers first, target PC + B-immediate second
      OPCODE_BRANCH: begin
        branch_dec_o = 1'b1;
        rf_ren_a     = 1'b1;
        rf_ren_b     = 1'b1;
        unique case (instr.b.funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_insn   = 1'b1;
        endcase
        if (instr_first_cycle_i) begin
          op_b_sel_o = OP_B_REG_B;
        end else begin
          alu_operator_o = ALU_ADD;
          op_a_sel_o     = OP_A_CURRPC;
          imm_b_sel_o    = IMM_B_B;
        end
      end

      // Type 00 word, 01 half, 10 byte
      OPCODE_LOAD: begin
        lsu_req_dec_o  = 1'b1;
        rf_ren_a       = 1'b1;
        rf_we_dec_o    = 1'b1;
        lsu_sign_ext_o = ~instr.i.funct3[2];
        unique case (instr.i.funct3)
          3'b000, 3'b100: lsu_type_o   = 2'b10;
          3'b001, 3'b101: lsu_type_o   = 2'b01;
          3'b010:         lsu_type_o   = 2'b00;
          default:        illegal_insn = 1'b1;
        endcase
      end

      OPCODE_STORE: begin
        lsu_req_dec_o = 1'b1;
        lsu_we_o      = 1'b1;
        rf_ren_a      = 1'b1;
        rf_ren_b      = 1'b1;
        imm_b_sel_o   = IMM_B_S;
        unique case (instr.s.funct3)
          3'b000:  lsu_type_o   = 2'b10;
          3'b001:  lsu_type_o   = 2'b01;
          3'b010:  lsu_type_o   = 2'b00;
          default: illegal_insn = 1'b1;
        endcase
      end

      default: illegal_insn = 1'b1;
    endcase
  end

  // Flags and read enables only for a valid word
  assign illegal_insn_o = instr_valid_i & illegal_insn;
  assign rf_ren_a_dec_o = instr_valid_i & ~illegal_insn & rf_ren_a;
  assign rf_ren_b_dec_o = instr_valid_i & ~illegal_insn & rf_ren_b;

endmodule

/* design/id_defs.svh */
// Width macros shared by the decode stage RTL and packages
// Include wherever a data, register address or instruction width is needed

`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Data and address width
`define ID_XLEN 32

// Register file address width
`define ID_REG_AW 5

// Instruction word width
`define ID_INSTR_W 32

`endif

/* design/id_isa_pkg.sv */
// RV32I instruction set types for the decode stage
// Opcodes, function codes, instruction format views and ALU operators

`include "id_defs.svh"

package id_isa_pkg;

  // Legal major opcodes
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // funct7 values, base and alternate (SUB, SRA)
  localparam logic [6:0] FUNCT7_BASE = 7'h00;
  localparam logic [6:0] FUNCT7_ALT  = 7'h20;

  // ALU operators, compares last
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_XOR  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_AND  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_GE   = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats, one word seen through six views
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`ID_REG_AW-1:0] rs2;
    logic [`ID_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`ID_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [`ID_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`ID_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [`ID_REG_AW-1:0] rs2;
    logic [`ID_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm12;
    logic [5:0]            imm10_5;
    logic [`ID_REG_AW-1:0] rs2;
    logic [`ID_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm4_1;
    logic                  imm11;
    logic [6:0]            opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [`ID_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm20;
    logic [9:0]            imm10_1;
    logic                  imm11;
    logic [7:0]            imm19_12;
    logic [`ID_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

/* design/id_operand_mux.sv */
// ALU operand selection for the decode stage
// Picks operand A and B from register data, PC and the decoded immediates

`timescale 1ns/1ns
`include "id_defs.svh"

module id_operand_mux (
  input  id_ctrl_pkg::op_a_sel_e  op_a_sel_i,
  input  id_ctrl_pkg::op_b_sel_e  op_b_sel_i,
  input  id_ctrl_pkg::imm_b_sel_e imm_b_sel_i,

  input  logic [`ID_XLEN-1:0]     imm_i_i,
  input  logic [`ID_XLEN-1:0]     imm_s_i,
  input  logic [`ID_XLEN-1:0]     imm_b_i,
  input  logic [`ID_XLEN-1:0]     imm_u_i,
  input  logic [`ID_XLEN-1:0]     imm_j_i,

  input  logic [`ID_XLEN-1:0]     rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]     rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0]     pc_id_i,

  output logic [`ID_XLEN-1:0]     alu_operand_a_o,
  output logic [`ID_XLEN-1:0]     alu_operand_b_o
);

  import id_ctrl_pkg::*;

  logic [`ID_XLEN-1:0] imm_b;

  // Immediate for operand B, INCR_PC gives the link offset
  always_comb begin : imm_b_mux
    unique case (imm_b_sel_i)
      IMM_B_I:       imm_b = imm_i_i;
      IMM_B_S:       imm_b = imm_s_i;
      IMM_B_B:       imm_b = imm_b_i;
      IMM_B_U:       imm_b = imm_u_i;
      IMM_B_J:       imm_b = imm_j_i;
      IMM_B_INCR_PC: imm_b = `ID_XLEN'(4);
      default:       imm_b = `ID_XLEN'(4);
    endcase
  end

  // Operand A
  always_comb begin : op_a_mux
    unique case (op_a_sel_i)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      OP_A_ZERO:   alu_operand_a_o = '0;
      default:     alu_operand_a_o = pc_id_i;
    endcase
  end

  // Operand B
  assign alu_operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

/* design/id_stage.sv */
// Decode stage top of the RV32I core
// Connects decoder, operand mux and controller to the fetch, EX, LSU and RF ports

`timescale 1ns/1ns
`include "id_defs.svh"

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Fetch
  input  logic                   instr_valid_i,
  input  logic [`ID_INSTR_W-1:0] instr_rdata_i,
  input  logic [`ID_XLEN-1:0]    pc_id_i,
  output logic                   id_in_ready_o,
  output logic                   illegal_insn_o,
  output logic                   pc_set_o,
  output logic                   instr_done_o,

  // EX
  input  logic                   branch_decision_i,
  output id_isa_pkg::alu_op_e    alu_operator_o,
  output logic [`ID_XLEN-1:0]    alu_operand_a_o,
  output logic [`ID_XLEN-1:0]    alu_operand_b_o,

  // LSU
  input  logic                   lsu_resp_valid_i,
  output logic                   lsu_req_o,
  output logic                   lsu_we_o,
  output logic [1:0]             lsu_type_o,
  output logic                   lsu_sign_ext_o,
  output logic [`ID_XLEN-1:0]    lsu_wdata_o,

  // Register file
  input  logic [`ID_XLEN-1:0]    rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_b_i,
  output logic [`ID_REG_AW-1:0]  rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]  rf_raddr_b_o,
  output logic                   rf_ren_a_o,
  output logic                   rf_ren_b_o,
  output logic [`ID_REG_AW-1:0]  rf_waddr_o,
  output logic                   rf_we_o
);

  import id_ctrl_pkg::*;

  logic                instr_first_cycle;
  logic                lsu_req_dec, branch_dec, jump_dec, rf_we_dec;
  op_a_sel_e           op_a_sel;
  op_b_sel_e           op_b_sel;
  imm_b_sel_e          imm_b_sel;
  logic [`ID_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  id_decoder decoder_i (
    .instr_valid_i      (instr_valid_i),
    .instr_rdata_i      (instr_rdata_i),
    .instr_first_cycle_i(instr_first_cycle),
    .illegal_insn_o     (illegal_insn_o),
    .lsu_req_dec_o      (lsu_req_dec),
    .branch_dec_o       (branch_dec),
    .jump_dec_o         (jump_dec),
    .rf_we_dec_o        (rf_we_dec),
    .lsu_we_o           (lsu_we_o),
    .lsu_type_o         (lsu_type_o),
    .lsu_sign_ext_o     (lsu_sign_ext_o),
    .rf_ren_a_dec_o     (rf_ren_a_o),
    .rf_ren_b_dec_o     (rf_ren_b_o),
    .rf_raddr_a_o       (rf_raddr_a_o),
    .rf_raddr_b_o       (rf_raddr_b_o),
    .rf_waddr_o         (rf_waddr_o),
    .alu_operator_o     (alu_operator_o),
    .op_a_sel_o         (op_a_sel),
    .op_b_sel_o         (op_b_sel),
    .imm_b_sel_o        (imm_b_sel),
    .imm_i_o            (imm_i),
    .imm_s_o            (imm_s),
    .imm_b_o            (imm_b),
    .imm_u_o            (imm_u),
    .imm_j_o            (imm_j)
  );

  id_operand_mux operand_mux_i (
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_b_sel_i    (imm_b_sel),
    .imm_i_i        (imm_i),
    .imm_s_i        (imm_s),
    .imm_b_i        (imm_b),
    .imm_u_i        (imm_u),
    .imm_j_i        (imm_j),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .pc_id_i        (pc_id_i),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  id_controller controller_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .illegal_insn_i     (illegal_insn_o),
    .lsu_req_dec_i      (lsu_req_dec),
    .branch_dec_i       (branch_dec),
    .jump_dec_i         (jump_dec),
    .rf_we_dec_i        (rf_we_dec),
    .branch_decision_i  (branch_decision_i),
    .lsu_resp_valid_i   (lsu_resp_valid_i),
    .instr_first_cycle_o(instr_first_cycle),
    .lsu_req_o          (lsu_req_o),
    .rf_we_o            (rf_we_o),
    .pc_set_o           (pc_set_o),
    .instr_done_o       (instr_done_o),
    .id_in_ready_o      (id_in_ready_o)
  );

  // Store data straight from register file port B
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

/* verif/id_stage_checker.sv */
// Concurrent assertions on the decode stage ports
// Attached to every id_stage instance by the bind at the end of this file

`timescale 1ns/1ns

module id_stage_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic pc_set_i,
  input logic lsu_req_i,
  input logic illegal_insn_i,
  input logic rf_we_i,
  input logic instr_done_i
);

  // Failed assertions so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // PC set is a one cycle pulse
  pc_set_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else begin
      $error("pc_set_o high on two consecutive cycles");
      fail_count++;
    end

  // One request per load/store
  lsu_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |=> !lsu_req_i)
    else begin
      $error("lsu_req_o high on two consecutive cycles");
      fail_count++;
    end

  // Illegal words have no side effects
  illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_i |-> !rf_we_i && !lsu_req_i)
    else begin
      $error("illegal_insn_o together with rf_we_o or lsu_req_o");
      fail_count++;
    end

  // Register write only in the done cycle
  we_in_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_we_i |-> instr_done_i)
    else begin
      $error("rf_we_o high without instr_done_o");
      fail_count++;
    end

endmodule

bind id_stage id_stage_checker port_checker_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .pc_set_i      (pc_set_o),
  .lsu_req_i     (lsu_req_o),
  .illegal_insn_i(illegal_insn_o),
  .rf_we_i       (rf_we_o),
  .instr_done_i  (instr_done_o)
);

/* verif/id_stage_tb.sv */
// Testbench for the decode stage
// Replays instruction vectors from verif/id_stage_vectors.txt through fetch
// and memory models and checks decode results, cycle counts and strobes

`timescale 1ns/1ns
`include "id_defs.svh"

module id_stage_tb;

  localparam int CYCLE_LIMIT = 20;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   instr_valid_i;
  logic [`ID_INSTR_W-1:0] instr_rdata_i;
  logic [`ID_XLEN-1:0]    pc_id_i;
  logic                   branch_decision_i;
  logic                   lsu_resp_valid_i;
  logic [`ID_XLEN-1:0]    rf_rdata_a_i, rf_rdata_b_i;
  logic                   id_in_ready_o, illegal_insn_o, pc_set_o, instr_done_o;
  logic [4:0]             alu_operator_o;
  logic [`ID_XLEN-1:0]    alu_operand_a_o, alu_operand_b_o;
  logic                   lsu_req_o, lsu_we_o, lsu_sign_ext_o;
  logic [1:0]             lsu_type_o;
  logic [`ID_XLEN-1:0]    lsu_wdata_o;
  logic [`ID_REG_AW-1:0]  rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
  logic                   rf_ren_a_o, rf_ren_b_o, rf_we_o;

  // Current vector, flags are illegal, ren_a, ren_b, lsu_req, lsu_we, sign_ext
  logic [31:0] v_instr, v_pc, v_rs1, v_rs2, v_a, v_b, v_b2;
  logic [4:0]  v_op;
  logic [5:0]  v_flags;
  logic [1:0]  v_typ;
  logic        v_bd, v_we;
  int          v_lat, v_cyc, v_ps;
  string       v_name;

  int   check_count = 0;
  int   error_count = 0;
  int   mem_latency = 0;
  int   mem_wait = 0;
  logic timed_out = 1'b0;

  id_stage id_stage_i (.*);

  always #5 clk_i = ~clk_i;

  // Memory model, response comes mem_latency cycles after the request
  initial begin
    lsu_resp_valid_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (lsu_req_o) begin
        mem_wait = mem_latency;
      end
      @(negedge clk_i);
      lsu_resp_valid_i = (mem_wait == 1);
      if (mem_wait > 0) begin
        mem_wait--;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("Error %s %s: expected %h, actual %h", v_name, field, expected, actual);
    end
  endtask

  // Control outputs with no instruction in the stage
  task automatic check_quiet();
    check_value("pc_set_o", 1'b0, pc_set_o);
    check_value("lsu_req_o", 1'b0, lsu_req_o);
    check_value("rf_we_o", 1'b0, rf_we_o);
    check_value("instr_done_o", 1'b0, instr_done_o);
    check_value("illegal_insn_o", 1'b0, illegal_insn_o);
    check_value("rf_ren_a_o", 1'b0, rf_ren_a_o);
    check_value("rf_ren_b_o", 1'b0, rf_ren_b_o);
  endtask

  // First cycle decode, operands and LSU attributes
  task automatic check_decode();
    check_value("illegal_insn_o", v_flags[5], illegal_insn_o);
    check_value("rf_ren_a_o", v_flags[4], rf_ren_a_o);
    check_value("rf_ren_b_o", v_flags[3], rf_ren_b_o);
    if (v_flags[4]) begin
      check_value("rf_raddr_a_o", v_instr[19:15], rf_raddr_a_o);
    end
    if (v_flags[3]) begin
      check_value("rf_raddr_b_o", v_instr[24:20], rf_raddr_b_o);
    end
    // Operands of an illegal word mean nothing
    if (!v_flags[5]) begin
      check_value("alu_operator_o", v_op, alu_operator_o);
      check_value("alu_operand_a_o", v_a, alu_operand_a_o);
      check_value("alu_operand_b_o", v_b, alu_operand_b_o);
    end
    if (v_flags[2]) begin
      check_value("lsu_we_o", v_flags[1], lsu_we_o);
      check_value("lsu_type_o", v_typ, lsu_type_o);
      if (v_flags[1]) begin
        check_value("lsu_wdata_o", v_rs2, lsu_wdata_o);
      end else begin
        check_value("lsu_sign_ext_o", v_flags[0], lsu_sign_ext_o);
      end
    end
  endtask

  task automatic check_cycle(input int cycle);
    logic last;
    last = (cycle == v_cyc);
    check_value("instr_done_o", last, instr_done_o);
    check_value("id_in_ready_o", last, id_in_ready_o);
    check_value("pc_set_o", cycle == v_ps, pc_set_o);
    check_value("rf_we_o", last && v_we, rf_we_o);
    check_value("lsu_req_o", cycle == 1 && v_flags[2], lsu_req_o);
    if (cycle == 1) begin
      check_decode();
    end
    // Second cycle of a taken branch or jump, target or link address
    if (cycle == 2 && v_ps != 0) begin
      check_value("alu_operand_a_o cycle 2", v_pc, alu_operand_a_o);
      check_value("alu_operand_b_o cycle 2", v_b2, alu_operand_b_o);
    end
    if (last && v_we) begin
      check_value("rf_waddr_o", v_instr[11:7], rf_waddr_o);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Fetch model
  //////////////////////////////////////////////////////////////////////////

  // Called at a falling edge, holds the word until done
  task automatic run_instruction();
    int   cycle;
    logic done;
    cycle             = 0;
    done              = 1'b0;
    instr_valid_i     = 1'b1;
    instr_rdata_i     = v_instr;
    pc_id_i           = v_pc;
    rf_rdata_a_i      = v_rs1;
    rf_rdata_b_i      = v_rs2;
    branch_decision_i = v_bd;
    mem_latency       = v_lat;
    while (!done && cycle < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle++;
      check_cycle(cycle);
      done = instr_done_o;
    end
    if (!done) begin
      error_count++;
      timed_out = 1'b1;
      $display("Timeout: %s not done within %0d cycles", v_name, CYCLE_LIMIT);
    end
    @(negedge clk_i);
    instr_valid_i = 1'b0;
  endtask

  initial begin
    int    fd;
    int    n;
    int    idles;
    int    vector_count;
    logic  redirect;
    string line;
    vector_count      = 0;
    redirect          = 1'b0;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    branch_decision_i = 1'b0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    v_name            = "reset";
    void'($urandom(32'hd0f36cb5));

    // Reset for two cycles, then one idle cycle with valid low
    repeat (2) begin
      @(posedge clk_i);
      check_quiet();
    end
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_quiet();
    @(negedge clk_i);

    fd = $fopen("verif/id_stage_vectors.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open verif/id_stage_vectors.txt");
    end else begin
      while (!timed_out && $fgets(line, fd) > 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %d %h %h %h %h %d %h %d %b %h %s",
                      v_instr, v_pc, v_rs1, v_rs2, v_bd, v_lat, v_op, v_a, v_b,
                      v_b2, v_cyc, v_we, v_ps, v_flags, v_typ, v_name);
          if (n != 16) begin
            error_count++;
            $display("Vector line could not be parsed: %s", line);
          end else begin
            // Fetch bubbles between instructions
            idles = $urandom_range(2, 0);
            // Fetch restarts at the new PC, so a PC set costs at least one bubble
            if (redirect && idles == 0) begin
              idles = 1;
            end
            repeat (idles) @(negedge clk_i);
            run_instruction();
            redirect = (v_ps != 0);
            vector_count++;
          end
        end
      end
      $fclose(fd);
    end
    if (vector_count == 0) begin
      error_count++;
      $display("No instruction vectors were run");
    end

    $display("Summary: %0d vectors, %0d checks, %0d errors, %0d assertion failures",
             vector_count, check_count, error_count,
             id_stage_i.port_checker_i.fail_count);
    if (error_count == 0 && id_stage_i.port_checker_i.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verif/id_stage_vectors.txt */
# instr pc rs1_data rs2_data br_taken mem_lat alu_op op_a op_b op_b_cycle2 cycles rf_we pc_set_cycle
# flags(illegal ren_a ren_b lsu_req lsu_we sign_ext, binary) lsu_type name; lat, cycles, pc_set_cycle decimal
002081b3 00000100 12345678 0000000f 0 0 00 12345678 0000000f 00000000 1 1 0 011000 0 add
407302b3 00000104 00000064 00000010 0 0 01 00000064 00000010 00000000 1 1 0 011000 0 sub
403150b3 00000108 f0000000 00000004 0 0 07 f0000000 00000004 00000000 1 1 0 011000 0 sra
fff58513 0000010c 00000020 deadbeef 0 0 00 00000020 ffffffff 00000000 1 1 0 010000 0 addi
7ff2b213 00000110 00000005 deadbeef 0 0 09 00000005 000007ff 00000000 1 1 0 010000 0 sltiu
4033d313 00000114 80000000 deadbeef 0 0 07 80000000 00000403 00000000 1 1 0 010000 0 srai
abcde437 00000118 11111111 22222222 0 0 00 00000000 abcde000 00000000 1 1 0 000000 0 lui
80000497 0000011c 11111111 22222222 0 0 00 0000011c 80000000 00000000 1 1 0 000000 0 auipc
0086a603 00000120 00002000 0badf00d 0 1 00 00002000 00000008 00000000 2 1 0 010101 0 lw
ffc7c703 00000124 00003000 0badf00d 0 3 00 00003000 fffffffc 00000000 4 1 0 010100 2 lbu
00211083 00000128 00004000 0badf00d 0 4 00 00004000 00000002 00000000 5 1 0 010101 1 lh
00532623 0000012c 00005000 cafef00d 0 2 00 00005000 0000000c 00000000 3 0 0 011110 0 sw
fe740fa3 00000130 00006000 000000a5 0 1 00 00006000 ffffffff 00000000 2 0 0 011110 2 sb
00208863 00000134 00000001 00000002 0 0 0a 00000001 00000002 00000000 1 0 0 011000 0 beq_nt
fe419ce3 00000138 00000003 00000004 1 0 0b 00000003 00000004 fffffff8 2 0 2 011000 0 bne_t
0062e0e3 0000013c 00000005 ffffffff 1 0 0e 00000005 ffffffff 00000800 2 0 2 011000 0 bltu_t
100000ef 00000140 33333333 44444444 0 0 00 00000140 00000100 00000004 2 1 1 000000 0 jal
ffdff2ef 00000144 33333333 44444444 0 0 00 00000144 fffffffc 00000004 2 1 1 000000 0 jal_neg
010100e7 00000148 00001000 44444444 0 0 00 00001000 00000010 00000004 2 1 1 010000 0 jalr
ffffffff 0000014c 55555555 66666666 0 0 00 00000000 00000000 00000000 1 0 0 100000 0 ill_op
023100b3 00000150 55555555 66666666 0 0 00 00000000 00000000 00000000 1 0 0 100000 0 mul
0006b603 00000154 55555555 66666666 0 1 00 00000000 00000000 00000000 1 0 0 100000 0 ld
00000000 00000158 55555555 66666666 0 0 00 00000000 00000000 00000000 1 0 0 100000 0 zero
